/* source/jedro_config.svh */
// Width and reset-value macros for the RV32I decode stage
`ifndef JEDRO_CONFIG_SVH
`define JEDRO_CONFIG_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

// Instruction and data word
`define JEDRO_DATA_WIDTH 32

`define JEDRO_REG_ADDR_WIDTH 5   // x0..x31

// Store/load bit plus funct3
`define JEDRO_LSU_CTRL_WIDTH 4

//////////////////////////////////////////////////
// Fixed constants
//////////////////////////////////////////////////

`define JEDRO_PC_RESET 32'h0000_0000   // Buffered address after reset

`endif

/* source/jedro_pkg.sv */
// Shared word, register address, opcode, ALU op, LSU control and FSM state types
`include "jedro_config.svh"

package jedro_pkg;

  typedef logic [`JEDRO_DATA_WIDTH-1:0]     word_t;
  typedef logic [`JEDRO_REG_ADDR_WIDTH-1:0] reg_addr_t;

  //////////////////////////////////////////////////
  // Major opcodes in instruction bits [6:0]
  //////////////////////////////////////////////////
  typedef enum logic [6:0] {
    OPC_LOAD    = 7'b0000011,
    OPC_MISCMEM = 7'b0001111,  // FENCE
    OPC_OPIMM   = 7'b0010011,
    OPC_AUIPC   = 7'b0010111,
    OPC_STORE   = 7'b0100011,
    OPC_OP      = 7'b0110011,
    OPC_LUI     = 7'b0110111,
    // Flagged illegal by this decoder
    OPC_BRANCH  = 7'b1100011,
    OPC_JALR    = 7'b1100111,
    OPC_JAL     = 7'b1101111,
    OPC_SYSTEM  = 7'b1110011
  } opcode_e;

  // Encoded as {instr[30], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  typedef struct packed {
    logic                             store_load;  // High for stores (opcode bit 5)
    logic [`JEDRO_LSU_CTRL_WIDTH-2:0] funct3;      // Access width and sign
  } lsu_ctrl_t;

  //////////////////////////////////////////////////
  // Decoder FSM
  //////////////////////////////////////////////////
  typedef enum logic [3:0] {
    ST_OK,
    ST_STALL,
    ST_LSU_CALC_ADDR,        // First store cycle
    ST_LSU_STORE,
    ST_LSU_LOAD_CALC_ADDR,   // First load cycle
    ST_LSU_LOAD,
    ST_LSU_LOAD_WAIT_0,
    ST_LSU_LOAD_WAIT_1,
    ST_LSU_LOAD_WAIT_2,
    ST_ILLEGAL
  } dec_state_e;

endpackage

/* source/decode_if.sv */
// Instruction field and immediate bundle between the field decoder and its users
`timescale 1ns/100ps

interface decode_if;
  import jedro_pkg::*;

  opcode_e   opcode;
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  logic [2:0] funct3;
  logic      alt_bit;      // instr[30], SUB and SRA select
  logic      shift_legal;  // funct7 fits a shift
  word_t     imm_i;
  word_t     imm_sh;
  word_t     imm_s;
  word_t     imm_u;

  modport src (
    output opcode, rd, rs1, rs2, funct3, alt_bit, shift_legal,
    output imm_i, imm_sh, imm_s, imm_u
  );

  modport dst (
    input opcode, rd, rs1, rs2, funct3, alt_bit, shift_legal,
    input imm_i, imm_sh, imm_s, imm_u
  );

endinterface

/* source/instr_field_decode.sv */
// Instruction field split and I, shift, S and U immediate generation
`timescale 1ns/100ps
`include "jedro_config.svh"

module instr_field_decode (
  input  jedro_pkg::word_t instr_i,
  decode_if.src            dec
);
  import jedro_pkg::*;

  localparam int unsigned XLEN = `JEDRO_DATA_WIDTH;

  logic [6:0] funct7;

  //////////////////////////////////////////////////
  // Register and function fields
  //////////////////////////////////////////////////
  assign dec.opcode  = opcode_e'(instr_i[6:0]);
  assign dec.rd      = instr_i[11:7];
  assign dec.funct3  = instr_i[14:12];
  assign dec.rs1     = instr_i[19:15];
  assign dec.rs2     = instr_i[24:20];
  assign dec.alt_bit = instr_i[30];

  assign funct7 = instr_i[31:25];

  // Only 0000000 and 0100000 are valid shift encodings
  assign dec.shift_legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);

  //////////////////////////////////////////////////
  // Immediates
  //////////////////////////////////////////////////

  // I-type from bits [31:20]
  assign dec.imm_i = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};

  // Shamt sign extended from bit 24
  assign dec.imm_sh = {{(XLEN-5){instr_i[24]}}, instr_i[24:20]};

  // S-type is split around rd
  assign dec.imm_s = {{(XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};

  assign dec.imm_u = {instr_i[31:12], 12'h000};  // Upper 20 bits over a zero low half

endmodule

/* source/raw_hazard_detect.sv */
// Previous destination register tracking and read-after-write hazard detection
`timescale 1ns/100ps

module raw_hazard_detect (
  input  logic  clk_i,
  input  logic  rstn_i,
  input  logic  instr_valid_i,
  decode_if.dst dec,
  output logic  raw_hazard_o
);
  import jedro_pkg::*;

  reg_addr_t prev_rd;    // rd of the instruction seen last clock
  reg_addr_t next_rd;
  logic      reads_rs1;
  logic      reads_rs2;

  // Register use per opcode
  always_comb begin
    next_rd   = '0;
    reads_rs1 = 1'b0;
    reads_rs2 = 1'b0;
    case (dec.opcode)
      OPC_OP: begin
        next_rd   = dec.rd;
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b1;
      end
      OPC_STORE: begin
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b1;
      end
      OPC_OPIMM, OPC_LOAD: begin
        next_rd   = dec.rd;
        reads_rs1 = 1'b1;
      end
      OPC_LUI, OPC_AUIPC: next_rd = dec.rd;
      default: next_rd = '0;
    endcase
    if (!instr_valid_i) begin
      next_rd = '0;  // Nothing gets written
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      prev_rd <= '0;
    end else begin
      prev_rd <= next_rd;
    end
  end

  // x0 never causes a hazard
  assign raw_hazard_o = (prev_rd != '0) &&
                        ((reads_rs1 && (dec.rs1 == prev_rd)) ||
                         (reads_rs2 && (dec.rs2 == prev_rd)));

endmodule

/* source/decode_ctrl.sv */
// Decoder sequencing FSM with registered ALU, register file and LSU controls
`timescale 1ns/100ps
`include "jedro_config.svh"

module decode_ctrl (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  logic                  instr_valid_i,
  input  jedro_pkg::word_t      instr_addr_i,
  decode_if.dst                 dec,
  input  logic                  raw_hazard_i,
  output jedro_pkg::word_t      instr_addr_o,
  output logic                  ready_o,
  output logic                  use_pc_o,
  output logic                  illegal_instr_o,
  output jedro_pkg::alu_op_e    alu_sel_o,
  output jedro_pkg::reg_addr_t  alu_dest_addr_o,
  output logic                  alu_wb_o,
  output jedro_pkg::reg_addr_t  rf_addr_a_o,
  output jedro_pkg::reg_addr_t  rf_addr_b_o,
  output logic                  is_imm_o,
  output jedro_pkg::word_t      imm_ext_o,
  output logic                  lsu_ctrl_valid_o,
  output jedro_pkg::lsu_ctrl_t  lsu_ctrl_o,
  output jedro_pkg::reg_addr_t  lsu_regdest_o
);
  import jedro_pkg::*;

  dec_state_e state;
  dec_state_e state_next;

  logic      ready_w;
  logic      use_pc_w;
  logic      illegal_w;
  alu_op_e   alu_sel_w;
  reg_addr_t alu_dest_w;
  logic      alu_wb_w;
  reg_addr_t rf_addr_a_w;
  reg_addr_t rf_addr_b_w;
  logic      op_a_reg_w;    // ALU operand A from the register file
  logic      op_b_reg_w;
  word_t     imm_w;
  logic      lsu_valid_w;
  lsu_ctrl_t lsu_ctrl_w;
  reg_addr_t lsu_dest_w;

  logic hazard_stall;
  logic load_busy;
  logic shift_op;

  assign hazard_stall = raw_hazard_i && (state != ST_STALL);
  // Past the first cycle of a load
  assign load_busy    = state inside {ST_LSU_LOAD_CALC_ADDR, ST_LSU_LOAD,
                                      ST_LSU_LOAD_WAIT_0, ST_LSU_LOAD_WAIT_1};
  assign shift_op     = (dec.funct3[1:0] == 2'b01) && dec.shift_legal;

  //////////////////////////////////////////////////
  // Next state and output decode
  //////////////////////////////////////////////////
  always_comb begin
    state_next  = ST_OK;
    ready_w     = 1'b1;
    use_pc_w    = 1'b0;
    illegal_w   = 1'b0;
    alu_sel_w   = ALU_ADD;
    alu_dest_w  = '0;
    alu_wb_w    = 1'b0;
    rf_addr_a_w = '0;
    rf_addr_b_w = '0;
    op_a_reg_w  = 1'b0;
    op_b_reg_w  = 1'b0;
    imm_w       = '0;
    lsu_valid_w = 1'b0;
    lsu_ctrl_w  = '0;
    lsu_dest_w  = '0;

    case ({instr_valid_i, dec.opcode})
      {1'b1, OPC_OP}: begin
        alu_sel_w   = alu_op_e'({dec.alt_bit, dec.funct3});
        alu_dest_w  = dec.rd;
        rf_addr_a_w = dec.rs1;
        rf_addr_b_w = dec.rs2;
        op_a_reg_w  = 1'b1;
        op_b_reg_w  = 1'b1;
        if (hazard_stall) begin
          state_next = ST_STALL;
          ready_w    = 1'b0;
        end else begin
          alu_wb_w = 1'b1;
        end
      end

      {1'b1, OPC_OPIMM}: begin
        alu_dest_w  = dec.rd;
        rf_addr_a_w = dec.rs1;
        op_a_reg_w  = 1'b1;
        if (shift_op) begin
          alu_sel_w = alu_op_e'({dec.alt_bit, dec.funct3});
          imm_w     = dec.imm_sh;
        end else begin
          alu_sel_w = alu_op_e'({1'b0, dec.funct3});
          imm_w     = dec.imm_i;
        end
        if (hazard_stall) begin
          state_next = ST_STALL;
          ready_w    = 1'b0;
        end else begin
          alu_wb_w = 1'b1;
        end
      end

      {1'b1, OPC_LUI}, {1'b1, OPC_AUIPC}: begin
        use_pc_w   = (dec.opcode == OPC_AUIPC);  // LUI adds to x0
        alu_dest_w = dec.rd;
        op_a_reg_w = 1'b1;
        imm_w      = dec.imm_u;
        alu_wb_w   = 1'b1;
      end

      {1'b1, OPC_STORE}: begin
        rf_addr_a_w = dec.rs1;
        rf_addr_b_w = dec.rs2;
        ready_w     = 1'b0;
        if (hazard_stall && (state != ST_LSU_CALC_ADDR)) begin
          state_next = ST_STALL;
        end else if (state != ST_LSU_CALC_ADDR) begin
          state_next = ST_LSU_CALC_ADDR;  // rs1 + S immediate
          op_a_reg_w = 1'b1;
          imm_w      = dec.imm_s;
        end else begin
          state_next  = ST_LSU_STORE;     // rs2 goes out as store data
          op_b_reg_w  = 1'b1;
          lsu_valid_w = 1'b1;
          lsu_ctrl_w  = '{store_load: 1'b1, funct3: dec.funct3};
          ready_w     = 1'b1;
        end
      end

      {1'b1, OPC_LOAD}: begin
        rf_addr_a_w = dec.rs1;
        lsu_ctrl_w  = '{store_load: 1'b0, funct3: dec.funct3};
        lsu_dest_w  = dec.rd;
        ready_w     = 1'b0;
        if (hazard_stall && !load_busy) begin
          state_next = ST_STALL;
        end else if (!load_busy) begin
          state_next = ST_LSU_LOAD_CALC_ADDR;
          op_a_reg_w = 1'b1;
          imm_w      = dec.imm_i;
        end else if (state == ST_LSU_LOAD_CALC_ADDR) begin
          state_next  = ST_LSU_LOAD;
          lsu_valid_w = 1'b1;  // Request to the LSU
        end else if (state == ST_LSU_LOAD) begin
          state_next = ST_LSU_LOAD_WAIT_0;
        end else if (state == ST_LSU_LOAD_WAIT_0) begin
          state_next = ST_LSU_LOAD_WAIT_1;
        end else begin
          state_next = ST_LSU_LOAD_WAIT_2;
          ready_w    = 1'b1;
        end
      end

      {1'b1, OPC_MISCMEM}: state_next = ST_OK;  // FENCE has nothing to order here

      // Invalid fetch, branches, jumps, SYSTEM and unknown opcodes
      default: begin
        illegal_w  = 1'b1;
        state_next = ST_ILLEGAL;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Output register stage
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state            <= ST_OK;
      instr_addr_o     <= `JEDRO_PC_RESET;
      ready_o          <= 1'b1;
      use_pc_o         <= 1'b0;
      illegal_instr_o  <= 1'b0;
      alu_sel_o        <= ALU_ADD;
      alu_dest_addr_o  <= '0;
      alu_wb_o         <= 1'b0;
      rf_addr_a_o      <= '0;
      rf_addr_b_o      <= '0;
      is_imm_o         <= 1'b0;
      imm_ext_o        <= '0;
      lsu_ctrl_valid_o <= 1'b0;
      lsu_ctrl_o       <= '0;
      lsu_regdest_o    <= '0;
    end else begin
      state            <= state_next;
      instr_addr_o     <= instr_addr_i;
      ready_o          <= ready_w;
      use_pc_o         <= use_pc_w;
      illegal_instr_o  <= illegal_w;
      alu_sel_o        <= alu_sel_w;
      alu_dest_addr_o  <= alu_dest_w;
      alu_wb_o         <= alu_wb_w;
      rf_addr_a_o      <= rf_addr_a_w;
      rf_addr_b_o      <= rf_addr_b_w;
      is_imm_o         <= ~(op_a_reg_w & op_b_reg_w);
      imm_ext_o        <= imm_w;
      lsu_ctrl_valid_o <= lsu_valid_w;
      lsu_ctrl_o       <= lsu_ctrl_w;
      lsu_regdest_o    <= lsu_dest_w;
    end
  end

endmodule

/* source/jedro_decoder.sv */
// RV32I decode stage top level with field decoder, hazard unit and control FSM
`timescale 1ns/100ps

module jedro_decoder (
  input  logic                  clk_i,
  input  logic                  rstn_i,

  // Fetch side
  input  jedro_pkg::word_t      instr_i,
  input  jedro_pkg::word_t      instr_addr_i,
  input  logic                  instr_valid_i,
  output jedro_pkg::word_t      instr_addr_o,
  output logic                  ready_o,        // Takes a new instruction next cycle
  output logic                  use_pc_o,
  output logic                  illegal_instr_o,

  // ALU and register file
  output jedro_pkg::alu_op_e    alu_sel_o,
  output jedro_pkg::reg_addr_t  alu_dest_addr_o,
  output logic                  alu_wb_o,
  output jedro_pkg::reg_addr_t  rf_addr_a_o,
  output jedro_pkg::reg_addr_t  rf_addr_b_o,
  output logic                  is_imm_o,
  output jedro_pkg::word_t      imm_ext_o,

  // LSU
  output logic                  lsu_ctrl_valid_o,
  output jedro_pkg::lsu_ctrl_t  lsu_ctrl_o,
  output jedro_pkg::reg_addr_t  lsu_regdest_o
);

  logic raw_hazard;

  decode_if dec_bus ();

  instr_field_decode field_dec0 (
    .instr_i (instr_i),
    .dec     (dec_bus.src)
  );

  raw_hazard_detect hazard0 (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_valid_i (instr_valid_i),
    .dec           (dec_bus.dst),
    .raw_hazard_o  (raw_hazard)
  );

  // All outputs are registered inside the FSM
  decode_ctrl ctrl0 (
    .clk_i            (clk_i),
    .rstn_i           (rstn_i),
    .instr_valid_i    (instr_valid_i),
    .instr_addr_i     (instr_addr_i),
    .dec              (dec_bus.dst),
    .raw_hazard_i     (raw_hazard),
    .instr_addr_o     (instr_addr_o),
    .ready_o          (ready_o),
    .use_pc_o         (use_pc_o),
    .illegal_instr_o  (illegal_instr_o),
    .alu_sel_o        (alu_sel_o),
    .alu_dest_addr_o  (alu_dest_addr_o),
    .alu_wb_o         (alu_wb_o),
    .rf_addr_a_o      (rf_addr_a_o),
    .rf_addr_b_o      (rf_addr_b_o),
    .is_imm_o         (is_imm_o),
    .imm_ext_o        (imm_ext_o),
    .lsu_ctrl_valid_o (lsu_ctrl_valid_o),
    .lsu_ctrl_o       (lsu_ctrl_o),
    .lsu_regdest_o    (lsu_regdest_o)
  );

endmodule

/* tb/tb_jedro_decoder.sv */
// Instruction table, LFSR filler, checks and timeout for the RV32I decode stage testbench
`timescale 1ns/100ps
`include "jedro_config.svh"

module tb_jedro_decoder;
  import jedro_pkg::*;

  // Table row with expected values for the issue output cycle
  typedef struct packed {
    word_t     instr;
    logic      valid;
    int        hold;
    int        stall;      // Leading stall cycles
    logic      mem;        // Load or store
    alu_op_e   sel;
    reg_addr_t dest;
    reg_addr_t ra;
    reg_addr_t rb;
    reg_addr_t lsu_dest;
    logic      is_imm;
    logic      wb;
    logic      use_pc;
    logic      illegal;
    word_t     imm;
    word_t     imm_first;  // Address immediate of a load or store
    lsu_ctrl_t lsu_ctrl;
  } row_t;

  logic      clk_i;
  logic      rstn_i;
  word_t     instr_i;
  word_t     instr_addr_i;
  logic      instr_valid_i;
  word_t     instr_addr_o;
  logic      ready_o;
  logic      use_pc_o;
  logic      illegal_instr_o;
  alu_op_e   alu_sel_o;
  reg_addr_t alu_dest_addr_o;
  logic      alu_wb_o;
  reg_addr_t rf_addr_a_o;
  reg_addr_t rf_addr_b_o;
  logic      is_imm_o;
  word_t     imm_ext_o;
  logic      lsu_ctrl_valid_o;
  lsu_ctrl_t lsu_ctrl_o;
  reg_addr_t lsu_regdest_o;

  row_t        rows[$];
  reg_addr_t   prev_dest = '0;   // Model of the last written register
  logic [15:0] lfsr = 16'd85;
  int          checks = 0;
  int          errors = 0;
  int          cur_row = -1;
  int          cycles = 0;
  int          limit = 1000;

  jedro_decoder dut0 (
    .clk_i            (clk_i),
    .rstn_i           (rstn_i),
    .instr_i          (instr_i),
    .instr_addr_i     (instr_addr_i),
    .instr_valid_i    (instr_valid_i),
    .instr_addr_o     (instr_addr_o),
    .ready_o          (ready_o),
    .use_pc_o         (use_pc_o),
    .illegal_instr_o  (illegal_instr_o),
    .alu_sel_o        (alu_sel_o),
    .alu_dest_addr_o  (alu_dest_addr_o),
    .alu_wb_o         (alu_wb_o),
    .rf_addr_a_o      (rf_addr_a_o),
    .rf_addr_b_o      (rf_addr_b_o),
    .is_imm_o         (is_imm_o),
    .imm_ext_o        (imm_ext_o),
    .lsu_ctrl_valid_o (lsu_ctrl_valid_o),
    .lsu_ctrl_o       (lsu_ctrl_o),
    .lsu_regdest_o    (lsu_regdest_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;  // 8 ns period
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("sim failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////
  task automatic check_word(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: row %0d %s is %h, expected %h", $time, cur_row, what, got, exp);
    end
  endtask

  task automatic check_reg(input string what, input reg_addr_t got, input reg_addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: row %0d %s is x%0d, expected x%0d", $time, cur_row, what, got, exp);
    end
  endtask

  task automatic check_sel(input string what, input alu_op_e got, input alu_op_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: row %0d %s is %h, expected %h", $time, cur_row, what, got, exp);
    end
  endtask

  task automatic check_lsu(input string what, input lsu_ctrl_t got, input lsu_ctrl_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: row %0d %s is %h, expected %h", $time, cur_row, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: row %0d %s is %b, expected %b", $time, cur_row, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // Encoders, LFSR and expected values
  //////////////////////////////////////////////////
  function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input logic [2:0] f3,
                                  input reg_addr_t rd, input opcode_e opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                  input logic [2:0] f3, input reg_addr_t rd,
                                  input opcode_e opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t enc_u(input logic [19:0] imm, input reg_addr_t rd,
                                  input opcode_e opc);
    return {imm, rd, opc};
  endfunction

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          k;
    v = '0;
    for (k = 0; k < n; k++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic add_row(input word_t instr, input logic valid);
    row_t       r;
    logic [6:0] opc;
    logic [6:0] f7;
    logic [2:0] f3;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    logic       use_rs1;
    logic       use_rs2;
    opc     = instr[6:0];
    rd      = instr[11:7];
    f3      = instr[14:12];
    rs1     = instr[19:15];
    rs2     = instr[24:20];
    f7      = instr[31:25];
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    r        = '0;
    r.instr  = instr;
    r.valid  = valid;
    r.hold   = 1;
    r.is_imm = 1'b1;
    if (!valid) begin
      r.illegal = 1'b1;
    end else begin
      case (opc)
        OPC_OP: begin
          r.sel    = alu_op_e'({f7[5], f3});
          r.dest   = rd;
          r.ra     = rs1;
          r.rb     = rs2;
          r.is_imm = 1'b0;
          r.wb     = 1'b1;
          use_rs1  = 1'b1;
          use_rs2  = 1'b1;
        end
        OPC_OPIMM: begin
          r.dest  = rd;
          r.ra    = rs1;
          r.wb    = 1'b1;
          use_rs1 = 1'b1;
          if ((f3[1:0] == 2'b01) && ((f7 == 7'h00) || (f7 == 7'h20))) begin
            r.sel = alu_op_e'({f7[5], f3});
            r.imm = {{27{instr[24]}}, instr[24:20]};
          end else begin
            r.sel = alu_op_e'({1'b0, f3});
            r.imm = {{20{instr[31]}}, instr[31:20]};
          end
        end
        OPC_LUI, OPC_AUIPC: begin
          r.dest   = rd;
          r.imm    = {instr[31:12], 12'h000};
          r.wb     = 1'b1;
          r.use_pc = (opc == OPC_AUIPC);
        end
        OPC_STORE: begin
          r.hold      = 2;
          r.mem       = 1'b1;
          r.ra        = rs1;
          r.rb        = rs2;
          r.lsu_ctrl  = {1'b1, f3};
          r.imm_first = {{20{instr[31]}}, instr[31:25], instr[11:7]};
          use_rs1     = 1'b1;
          use_rs2     = 1'b1;
        end
        OPC_LOAD: begin
          r.hold      = 5;
          r.mem       = 1'b1;
          r.ra        = rs1;
          r.lsu_ctrl  = {1'b0, f3};
          r.lsu_dest  = rd;
          r.imm_first = {{20{instr[31]}}, instr[31:20]};
          use_rs1     = 1'b1;
        end
        OPC_MISCMEM: r.hold = 1;  // FENCE has no enables
        default: r.illegal = 1'b1;
      endcase
    end
    if ((prev_dest != '0) && ((use_rs1 && (rs1 == prev_dest)) ||
                              (use_rs2 && (rs2 == prev_dest)))) begin
      r.stall = 1;
    end
    r.hold = r.hold + r.stall;
    if (valid && (opc inside {OPC_OP, OPC_OPIMM, OPC_LUI, OPC_AUIPC, OPC_LOAD})) begin
      prev_dest = rd;
    end else begin
      prev_dest = '0;
    end
    rows.push_back(r);
  endtask

  // Random OP, OP-IMM, LUI and AUIPC fillers
  task automatic add_random_rows(input int n);
    int          i;
    logic [1:0]  kind;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    for (i = 0; i < n; i++) begin
      kind = 2'(rand_bits(2));
      rd   = reg_addr_t'(rand_bits(5));
      rs1  = reg_addr_t'(rand_bits(5));
      rs2  = reg_addr_t'(rand_bits(5));
      f3   = 3'(rand_bits(3));
      case (kind)
        2'd0: begin
          f7 = ((f3 == 3'd0 || f3 == 3'd5) && rand_bits(1) != 0) ? 7'h20 : 7'h00;
          add_row(enc_r(f7, rs2, rs1, f3, rd, OPC_OP), 1'b1);
        end
        2'd1: begin
          if (f3[1:0] == 2'b01) begin
            imm = {(f3[2] && rand_bits(1) != 0) ? 7'h20 : 7'h00, rs2};  // Legal shift
          end else begin
            imm = 12'(rand_bits(12));
          end
          add_row(enc_i(imm, rs1, f3, rd, OPC_OPIMM), 1'b1);
        end
        2'd2: add_row(enc_u(20'(rand_bits(20)), rd, OPC_LUI), 1'b1);
        default: add_row(enc_u(20'(rand_bits(20)), rd, OPC_AUIPC), 1'b1);
      endcase
    end
  endtask

  task automatic build_table();
    // ALU ops without hazards
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, OPC_OP), 1'b1);       // add x3, x1, x2
    add_row(enc_r(7'h20, 5'd6, 5'd5, 3'd0, 5'd4, OPC_OP), 1'b1);       // sub
    add_row(enc_r(7'h00, 5'd8, 5'd7, 3'd7, 5'd9, OPC_OP), 1'b1);       // and
    add_row(enc_i(12'hffb, 5'd8, 3'd0, 5'd7, OPC_OPIMM), 1'b1);        // addi -5
    add_row(enc_i({7'h20, 5'd7}, 5'd10, 3'd5, 5'd9, OPC_OPIMM), 1'b1); // srai
    add_row(enc_i({7'h21, 5'd3}, 5'd11, 3'd1, 5'd12, OPC_OPIMM), 1'b1);
    add_row(enc_i({7'h00, 5'd19}, 5'd1, 3'd1, 5'd13, OPC_OPIMM), 1'b1);
    add_row(enc_u(20'habcde, 5'd13, OPC_LUI), 1'b1);
    add_row(enc_u(20'h12345, 5'd14, OPC_AUIPC), 1'b1);
    // Read after write
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd15, OPC_OP), 1'b1);
    add_row(enc_r(7'h00, 5'd3, 5'd15, 3'd4, 5'd16, OPC_OP), 1'b1);     // Stalls on x15
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd0, OPC_OP), 1'b1);       // Writes x0
    add_row(enc_r(7'h00, 5'd4, 5'd0, 3'd0, 5'd19, OPC_OP), 1'b1);
    add_row(enc_r(7'h00, 5'd0, 5'd0, 3'd6, 5'd20, OPC_OP), 1'b1);      // Sources x0
    add_row(enc_i(12'd4, 5'd20, 3'd0, 5'd21, OPC_OPIMM), 1'b1);
    // Loads and stores
    add_row(enc_i(12'd16, 5'd2, 3'd2, 5'd22, OPC_LOAD), 1'b1);         // lw
    add_row(enc_i(12'hffc, 5'd22, 3'd4, 5'd23, OPC_LOAD), 1'b1);       // lbu after lw
    add_row(enc_s(12'hff8, 5'd5, 5'd6, 3'd2), 1'b1);                    // sw
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd24, OPC_OP), 1'b1);
    add_row(enc_s(12'h7f0, 5'd24, 5'd1, 3'd1), 1'b1);                   // sh of x24
    // Illegal and no-op
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, OPC_OP), 1'b0);       // Invalid fetch
    add_row(32'h0020_8463, 1'b1);  // beq
    add_row(32'h0080_006f, 1'b1);  // jal
    add_row(32'h0000_8067, 1'b1);  // jalr
    add_row(32'h0000_0073, 1'b1);  // ecall
    add_row(32'h0000_000b, 1'b1);  // Unknown custom-0
    add_row(32'h0ff0_000f, 1'b1);  // fence
    add_random_rows(12);
  endtask

  //////////////////////////////////////////////////
  // Row application
  //////////////////////////////////////////////////
  task automatic apply_row(input row_t r, input word_t addr);
    int c;
    instr_i       = r.instr;
    instr_valid_i = r.valid;
    instr_addr_i  = addr;
    for (c = 0; c < r.hold; c++) begin
      @(posedge clk_i);
      #1;
      check_bit("ready_o", ready_o, c == r.hold - 1);
      check_word("instr_addr_o", instr_addr_o, addr);
      check_bit("lsu_ctrl_valid_o", lsu_ctrl_valid_o, r.mem && (c == r.stall + 1));
      if (c < r.hold - 1) begin
        check_bit("alu_wb_o", alu_wb_o, 1'b0);
        check_bit("illegal_instr_o", illegal_instr_o, 1'b0);
      end
      if (r.mem && (c == r.stall)) begin  // Address calculation cycle
        check_word("imm_ext_o", imm_ext_o, r.imm_first);
        check_reg("rf_addr_a_o", rf_addr_a_o, r.ra);
      end
      if (c == r.hold - 1) begin
        check_bit("alu_wb_o", alu_wb_o, r.wb);
        check_sel("alu_sel_o", alu_sel_o, r.sel);
        check_reg("alu_dest_addr_o", alu_dest_addr_o, r.dest);
        check_reg("rf_addr_a_o", rf_addr_a_o, r.ra);
        check_reg("rf_addr_b_o", rf_addr_b_o, r.rb);
        check_bit("is_imm_o", is_imm_o, r.is_imm);
        check_word("imm_ext_o", imm_ext_o, r.imm);
        check_lsu("lsu_ctrl_o", lsu_ctrl_o, r.lsu_ctrl);
        check_reg("lsu_regdest_o", lsu_regdest_o, r.lsu_dest);
        check_bit("use_pc_o", use_pc_o, r.use_pc);
        check_bit("illegal_instr_o", illegal_instr_o, r.illegal);
      end
    end
  endtask

  initial begin
    rstn_i        = 1'b0;
    instr_i       = '0;
    instr_addr_i  = 32'h0000_00fc;
    instr_valid_i = 1'b0;
    build_table();
    limit = 16 + 20;
    foreach (rows[i]) begin
      limit += rows[i].hold;
    end
    repeat (16) @(posedge clk_i);
    #1;
    rstn_i = 1'b1;
    // Reset values
    check_bit("ready_o", ready_o, 1'b1);
    check_bit("alu_wb_o", alu_wb_o, 1'b0);
    check_bit("lsu_ctrl_valid_o", lsu_ctrl_valid_o, 1'b0);
    check_bit("illegal_instr_o", illegal_instr_o, 1'b0);
    check_bit("use_pc_o", use_pc_o, 1'b0);
    check_word("instr_addr_o", instr_addr_o, `JEDRO_PC_RESET);
    check_word("imm_ext_o", imm_ext_o, '0);
    check_reg("rf_addr_a_o", rf_addr_a_o, '0);
    foreach (rows[i]) begin
      cur_row = i;
      apply_row(rows[i], word_t'(32'h100 + 4 * i));
    end
    $display("Done: %0d checks, %0d value errors", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* jedro_decoder.f */
+incdir+source
source/jedro_pkg.sv
source/decode_if.sv
source/instr_field_decode.sv
source/raw_hazard_detect.sv
source/decode_ctrl.sv
source/jedro_decoder.sv
tb/tb_jedro_decoder.sv
